//--- rtl/aggr_bank.sv
`timescale 1ns/1ps

module aggr_bank (
    input  logic                 clk,
    input  logic                 reset,
    input  gnn_pkg::bank_beat_t  beat_in,
    output gnn_pkg::agg_result_t agg
);
    import gnn_pkg::*;

    logic                            in_stream;   // between sos and eos
    logic [num_lanes-1:0][sum_w-1:0] sum_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_stream <= 1'b0;
            agg.valid <= 1'b0;
        end else begin
            agg.valid <= beat_in.done_aggr;
            if (beat_in.sos)
                in_stream <= !beat_in.eos;
            else if (beat_in.eos)
                in_stream <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < num_lanes; l++) begin
            if (beat_in.sos)
                sum_q[l] <= sum_w'(beat_in.lanes[l]);   // restart
            else if (in_stream)
                sum_q[l] <= sum_q[l] + sum_w'(beat_in.lanes[l]);
        end
        if (beat_in.done_aggr)
            agg.sums <= sum_q;
    end

endmodule

//--- rtl/edge_pe.sv
`timescale 1ns/1ps

module edge_pe (
    input  logic                clk,
    input  logic                reset,
    input  gnn_pkg::task_t      task_in,
    input  gnn_pkg::nbr_resp_t  nbr_resp,
    input  gnn_pkg::fv_resp_t   fv_resp,
    output gnn_pkg::nbr_req_t   nbr_req,
    output gnn_pkg::fv_req_t    fv_req,
    output gnn_pkg::bank_beat_t bank_out
);
    import gnn_pkg::*;

    pe_state_t            state;
    pe_state_t            nx_state;
    logic [node_id_w-1:0] target_q;
    logic [node_id_w-1:0] nbr_ids [max_degree];
    logic [nbr_idx_w-1:0] fill;       // next free slot in nbr_ids
    logic [degree_w-1:0]  degree_q;
    logic [degree_w-1:0]  last_idx;
    logic [degree_w-1:0]  req_ptr;    // feature requests issued
    logic [degree_w-1:0]  rsp_cnt;    // feature beats forwarded

    assign last_idx = degree_q - 1'b1;

    assign nbr_req.req  = (state == req_nbr);   // one cycle, first beat lands next
    assign nbr_req.node = target_q;
    assign fv_req.req   = (state == req_fv);
    assign fv_req.node  = nbr_ids[req_ptr[nbr_idx_w-1:0]];

    always_comb begin
        nx_state = state;
        case (state)
            idle: begin
                if (task_in.valid)
                    nx_state = req_nbr;
            end
            req_nbr:
                nx_state = stream_nbr;
            stream_nbr: begin
                if (nbr_resp.eos)
                    nx_state = req_fv;
            end
            req_fv: begin
                if (req_ptr == last_idx)
                    nx_state = wait_fv;
            end
            wait_fv: begin
                if (fv_resp.valid && (rsp_cnt == last_idx))
                    nx_state = complete;
            end
            complete:
                nx_state = idle;
            default:
                nx_state = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            fill     <= '0;
            degree_q <= '0;
            req_ptr  <= '0;
            rsp_cnt  <= '0;
            bank_out <= '0;
        end else begin
            state    <= nx_state;
            bank_out <= '0;
            case (state)
                idle: begin
                    fill    <= '0;
                    req_ptr <= '0;
                    rsp_cnt <= '0;
                end
                stream_nbr: begin
                    fill <= fill + nbr_idx_w'(beat_ids);
                    if (nbr_resp.sos)
                        degree_q <= nbr_resp.degree;
                end
                req_fv:
                    req_ptr <= req_ptr + 1'b1;
                complete:
                    bank_out.done_aggr <= 1'b1;   // marker beat, no data
                default: ;
            endcase
            // responses come back to back, so the bank sees a gapless stream
            if (fv_resp.valid) begin
                bank_out.sos   <= (rsp_cnt == '0);
                bank_out.eos   <= (rsp_cnt == last_idx);
                bank_out.lanes <= fv_resp.lanes;
                rsp_cnt        <= rsp_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == idle) && task_in.valid)
            target_q <= task_in.target;
        // odd degree leaves a stale id in the top slot, never requested
        if (state == stream_nbr) begin
            for (int i = 0; i < beat_ids; i++)
                nbr_ids[fill + i] <= nbr_resp.ids[i];
        end
    end

endmodule

//--- rtl/feature_sram.sv
`timescale 1ns/1ps

module feature_sram (
    input  logic              clk,
    input  logic              reset,
    input  gnn_pkg::tbl_wr_t  wr,
    input  gnn_pkg::fv_req_t  req,
    output gnn_pkg::fv_resp_t resp
);
    import gnn_pkg::*;

    logic [num_lanes-1:0][lane_w-1:0] fv_mem [num_nodes];

    always_ff @(posedge clk) begin
        if (wr.fv_en)
            fv_mem[wr.node] <= wr.data;
    end

    always_ff @(posedge clk) begin
        if (reset)
            resp.valid <= 1'b0;
        else
            resp.valid <= req.req;
    end

    // read data lines up with valid
    always_ff @(posedge clk) begin
        resp.lanes <= fv_mem[req.node];
    end

endmodule

//--- rtl/gnn_aggr_top.sv
`timescale 1ns/1ps

module gnn_aggr_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [gnn_pkg::apb_addr_w-1:0] paddr,
    input  logic [gnn_pkg::apb_data_w-1:0] pwdata,
    output logic [gnn_pkg::apb_data_w-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr
);
    import gnn_pkg::*;

    tbl_wr_t     tbl_wr;
    task_t       task_w;
    nbr_req_t    nbr_req;
    nbr_resp_t   nbr_resp;
    fv_req_t     fv_req;
    fv_resp_t    fv_resp;
    bank_beat_t  bank_beat;
    agg_result_t agg;

    gnn_apb_regs gnn_apb_regs_i (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .agg      (agg),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .tbl_wr   (tbl_wr),
        .task_out (task_w)
    );

    neighbor_sram neighbor_sram_i (
        .clk   (clk),
        .reset (reset),
        .wr    (tbl_wr),
        .req   (nbr_req),
        .resp  (nbr_resp)
    );

    feature_sram feature_sram_i (
        .clk   (clk),
        .reset (reset),
        .wr    (tbl_wr),
        .req   (fv_req),
        .resp  (fv_resp)
    );

    edge_pe edge_pe_i (
        .clk      (clk),
        .reset    (reset),
        .task_in  (task_w),
        .nbr_resp (nbr_resp),
        .fv_resp  (fv_resp),
        .nbr_req  (nbr_req),
        .fv_req   (fv_req),
        .bank_out (bank_beat)
    );

    aggr_bank aggr_bank_i (
        .clk     (clk),
        .reset   (reset),
        .beat_in (bank_beat),
        .agg     (agg)
    );

endmodule

//--- rtl/gnn_apb_regs.sv
`timescale 1ns/1ps

module gnn_apb_regs (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [gnn_pkg::apb_addr_w-1:0] paddr,
    input  logic [gnn_pkg::apb_data_w-1:0] pwdata,
    input  gnn_pkg::agg_result_t           agg,
    output logic [gnn_pkg::apb_data_w-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr,
    output gnn_pkg::tbl_wr_t               tbl_wr,
    output gnn_pkg::task_t                 task_out
);
    import gnn_pkg::*;

    logic [degree_w-1:0]             degree_shadow [num_nodes];
    logic                            busy;
    logic [node_id_w-1:0]            last_target;
    logic [num_lanes-1:0][sum_w-1:0] result_q;
    logic                            access;
    logic                            wr_access;
    logic [region_w-1:0]             region;
    logic [node_id_w-1:0]            task_node;
    logic                            task_err;
    logic                            task_ok;

    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign region    = paddr[apb_addr_w-1 -: region_w];
    assign task_node = pwdata[node_id_w-1:0];
    assign task_err  = busy || (degree_shadow[task_node] == '0);
    assign task_ok   = wr_access && (region == region_task) && !task_err;

    assign pready  = 1'b1;   // zero wait states
    assign pslverr = wr_access && (((region == region_task) && task_err) ||
                                   (region == region_stat));

    always_comb begin
        tbl_wr        = '0;
        tbl_wr.nbr_en = wr_access && (region == region_nbr);
        tbl_wr.fv_en  = wr_access && (region == region_fv);
        tbl_wr.beat   = paddr[beat_w-1:0];
        tbl_wr.degree = pwdata[nbr_deg_lsb +: degree_w];
        if (region == region_nbr) begin
            tbl_wr.node = paddr[beat_w +: node_id_w];
            tbl_wr.data = tbl_data_w'(pwdata[beat_ids*node_id_w-1:0]);
        end else begin
            tbl_wr.node = paddr[node_id_w-1:0];
            tbl_wr.data = pwdata[tbl_data_w-1:0];
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite && (region == region_stat)) begin
            if (paddr[result_sel_bit]) begin
                prdata = result_q;   // {lane1, lane0}
            end else begin
                prdata[0] = busy;
                prdata[stat_target_lsb +: node_id_w] = last_target;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            last_target <= '0;
            result_q    <= '0;
            task_out    <= '0;
            for (int n = 0; n < num_nodes; n++)
                degree_shadow[n] <= '0;
        end else begin
            task_out.valid <= task_ok;   // one cycle after the accepted write
            if (task_ok) begin
                busy            <= 1'b1;
                last_target     <= task_node;
                task_out.target <= task_node;
            end
            if (agg.valid) begin
                busy     <= 1'b0;
                result_q <= agg.sums;
            end
            if (tbl_wr.nbr_en && (tbl_wr.beat == '0))
                degree_shadow[tbl_wr.node] <= tbl_wr.degree;
        end
    end

endmodule

//--- rtl/gnn_pkg.sv
package gnn_pkg;

    localparam int node_id_w  = 7;
    localparam int max_degree = 8;
    localparam int degree_w   = 4;
    localparam int beat_ids   = 2;
    localparam int lane_w     = 8;
    localparam int num_lanes  = 2;
    localparam int sum_w      = 16;
    localparam int apb_addr_w = 12;
    localparam int apb_data_w = 32;

    localparam int num_nodes  = 1 << node_id_w;
    localparam int nbr_beats  = max_degree / beat_ids;   // id beats per node
    localparam int beat_w     = $clog2(nbr_beats);
    localparam int nbr_idx_w  = $clog2(max_degree);
    localparam int tbl_data_w = num_lanes * lane_w;

    // apb map, region on paddr[11:10]
    // table regions are word indexed: nbr paddr[8:0] = {node, beat}, fv paddr[6:0] = node
    // nbr data: [13:0] two ids (low id first), [19:16] degree on beat 0 only
    // fv data: [15:0] = {lane1, lane0}
    // task at offset 0: [6:0] target
    // status at offset 0 (busy bit 0, last target [14:8]), result at offset 4
    localparam int          region_w        = 2;
    localparam logic [1:0]  region_nbr      = 2'd0;
    localparam logic [1:0]  region_fv       = 2'd1;
    localparam logic [1:0]  region_task     = 2'd2;
    localparam logic [1:0]  region_stat     = 2'd3;
    localparam int          nbr_deg_lsb     = 16;
    localparam int          stat_target_lsb = 8;
    localparam int          result_sel_bit  = 2;

    typedef struct packed {
        logic                 valid;
        logic [node_id_w-1:0] target;
    } task_t;

    typedef struct packed {
        logic                 req;
        logic [node_id_w-1:0] node;
    } nbr_req_t;

    typedef struct packed {
        logic                                sos;
        logic                                eos;
        logic [beat_ids-1:0][node_id_w-1:0]  ids;
        logic [degree_w-1:0]                 degree;
    } nbr_resp_t;

    typedef struct packed {
        logic                 req;
        logic [node_id_w-1:0] node;
    } fv_req_t;

    typedef struct packed {
        logic                             valid;
        logic [num_lanes-1:0][lane_w-1:0] lanes;
    } fv_resp_t;

    typedef struct packed {
        logic                             sos;
        logic                             eos;
        logic [num_lanes-1:0][lane_w-1:0] lanes;
        logic                             done_aggr;   // final beat of a task
    } bank_beat_t;

    typedef struct packed {
        logic                  nbr_en;
        logic                  fv_en;
        logic [node_id_w-1:0]  node;
        logic [beat_w-1:0]     beat;
        logic [tbl_data_w-1:0] data;
        logic [degree_w-1:0]   degree;
    } tbl_wr_t;

    typedef struct packed {
        logic                            valid;
        logic [num_lanes-1:0][sum_w-1:0] sums;
    } agg_result_t;

    typedef enum logic [2:0] {
        idle,
        req_nbr,
        stream_nbr,
        req_fv,
        wait_fv,
        complete
    } pe_state_t;

endpackage

//--- rtl/neighbor_sram.sv
`timescale 1ns/1ps

module neighbor_sram (
    input  logic               clk,
    input  logic               reset,
    input  gnn_pkg::tbl_wr_t   wr,
    input  gnn_pkg::nbr_req_t  req,
    output gnn_pkg::nbr_resp_t resp
);
    import gnn_pkg::*;

    logic [degree_w-1:0]                degree_mem [num_nodes];
    logic [beat_ids-1:0][node_id_w-1:0] id_mem [num_nodes*nbr_beats];
    logic                               active;   // beats still owed
    logic [node_id_w-1:0]               node_q;
    logic [beat_w-1:0]                  beat_q;
    logic [beat_w-1:0]                  last_q;
    logic [degree_w-1:0]                deg_rd;
    logic [degree_w-1:0]                deg_m1;
    logic [beat_w-1:0]                  last_rd;

    assign deg_rd  = degree_mem[req.node];
    assign deg_m1  = deg_rd - 1'b1;
    assign last_rd = deg_m1[beat_w:1];   // ceil(d/2) - 1

    always_ff @(posedge clk) begin
        if (wr.nbr_en) begin
            id_mem[{wr.node, wr.beat}] <= wr.data[beat_ids*node_id_w-1:0];
            if (wr.beat == '0)
                degree_mem[wr.node] <= wr.degree;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            beat_q   <= '0;
            resp.sos <= 1'b0;
            resp.eos <= 1'b0;
        end else begin
            resp.sos <= 1'b0;
            resp.eos <= 1'b0;
            if (active) begin
                resp.eos <= (beat_q == last_q);
                active   <= (beat_q != last_q);
                beat_q   <= beat_q + 1'b1;
            end else if (req.req) begin
                resp.sos <= 1'b1;
                resp.eos <= (last_rd == '0);   // single beat carries both
                active   <= (last_rd != '0);
                beat_q   <= beat_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            resp.ids <= id_mem[{node_q, beat_q}];
        end else begin
            resp.ids    <= id_mem[{req.node, beat_w'(0)}];
            resp.degree <= deg_rd;
            node_q      <= req.node;
            last_q      <= last_rd;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the GNN aggregation testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module gnn_aggr_tb -f sim.f -o Vgnn_aggr_tb

./obj_dir/Vgnn_aggr_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

//--- sim.f
rtl/gnn_pkg.sv
rtl/gnn_apb_regs.sv
rtl/neighbor_sram.sv
rtl/feature_sram.sv
rtl/edge_pe.sv
rtl/aggr_bank.sv
rtl/gnn_aggr_top.sv
sim/gnn_aggr_sva.sv
sim/gnn_aggr_tb.sv

//--- sim/gnn_aggr_sva.sv
`timescale 1ns/1ps

module gnn_aggr_sva (
    input logic                clk,
    input logic                reset,
    input gnn_pkg::nbr_req_t   nbr_req,
    input gnn_pkg::fv_req_t    fv_req,
    input gnn_pkg::fv_resp_t   fv_resp,
    input gnn_pkg::bank_beat_t bank_out
);

    logic in_task;   // from the neighbor request up to done_aggr

    always_ff @(posedge clk) begin
        if (reset)
            in_task <= 1'b0;
        else if (bank_out.done_aggr)
            in_task <= 1'b0;
        else if (nbr_req.req)
            in_task <= 1'b1;
    end

    fv_resp_follows_req: assert property (
        @(posedge clk) disable iff (reset) fv_req.req |=> fv_resp.valid
    ) else $error("feature response did not arrive one cycle after its request");

    done_without_sos: assert property (
        @(posedge clk) disable iff (reset) bank_out.done_aggr |-> !bank_out.sos
    ) else $error("done_aggr beat also carries sos");

    no_nbr_req_streaming: assert property (
        @(posedge clk) disable iff (reset) in_task |-> !nbr_req.req
    ) else $error("neighbor request raised while the PE is streaming");

endmodule

bind edge_pe gnn_aggr_sva gnn_aggr_sva_i (
    .clk      (clk),
    .reset    (reset),
    .nbr_req  (nbr_req),
    .fv_req   (fv_req),
    .fv_resp  (fv_resp),
    .bank_out (bank_out)
);

//--- sim/gnn_aggr_tb.sv
`timescale 1ns/1ps

module gnn_aggr_tb;
    import gnn_pkg::*;

    localparam int num_random  = 40;
    localparam int num_tasks   = num_random + 6;
    localparam int task_cycles = 200;
    localparam int load_cycles = num_nodes * (nbr_beats + 1) * 4;   // ~3 cycles per access
    localparam int wd_cycles   = load_cycles + task_cycles * num_tasks;

    localparam logic [node_id_w-1:0]  zero_node   = 7'd127;
    localparam logic [apb_addr_w-1:0] task_addr   = 12'h800;
    localparam logic [apb_addr_w-1:0] status_addr = 12'hc00;
    localparam logic [apb_addr_w-1:0] result_addr = 12'hc04;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // reference model tables
    logic [degree_w-1:0]  deg_tbl [num_nodes];
    logic [node_id_w-1:0] nbr_tbl [num_nodes][max_degree];
    logic [lane_w-1:0]    fv_tbl  [num_nodes][num_lanes];

    int errors = 0;
    int checks = 0;

    gnn_aggr_top gnn_aggr_top_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #2 clk = ~clk;

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout after %0d cycles, a task never finished", wd_cycles);
        $display("Test failed");
        $finish;
    end

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act == exp) else begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    // setup then access phase, sampled mid-cycle
    task automatic apb_access(input logic wr, input logic [apb_addr_w-1:0] addr,
                              input logic [apb_data_w-1:0] wdata,
                              output logic [apb_data_w-1:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        expect_eq("pready", 32'd1, 32'(pready));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [apb_addr_w-1:0] addr,
                             input logic [apb_data_w-1:0] data, output logic err);
        logic [apb_data_w-1:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [apb_addr_w-1:0] addr,
                            output logic [apb_data_w-1:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        expect_eq("read pslverr", 32'd0, 32'(err));
    endtask

    task automatic wait_idle(output logic [apb_data_w-1:0] status);
        status = 32'd1;
        while (status[0])
            apb_read(status_addr, status);
    endtask

    // plain sum over the first deg ids
    function automatic logic [31:0] model_result(input logic [node_id_w-1:0] t);
        logic [sum_w-1:0] s0;
        logic [sum_w-1:0] s1;
        s0 = '0;
        s1 = '0;
        for (int i = 0; i < int'(deg_tbl[t]); i++) begin
            s0 += sum_w'(fv_tbl[nbr_tbl[t][i]][0]);
            s1 += sum_w'(fv_tbl[nbr_tbl[t][i]][1]);
        end
        return {s1, s0};
    endfunction

    task automatic write_neighbors(input int n);
        logic [apb_data_w-1:0] data;
        logic                  err;
        for (int b = 0; b < nbr_beats; b++) begin
            data = '0;
            data[6:0]  = nbr_tbl[n][2*b];
            data[13:7] = nbr_tbl[n][2*b+1];
            if (b == 0)
                data[19:16] = deg_tbl[n];
            apb_write(apb_addr_w'((n << beat_w) | b), data, err);
            expect_eq("neighbor write pslverr", 32'd0, 32'(err));
        end
    endtask

    task automatic write_features(input int n);
        logic err;
        apb_write(12'h400 | apb_addr_w'(n), {16'd0, fv_tbl[n][1], fv_tbl[n][0]}, err);
        expect_eq("feature write pslverr", 32'd0, 32'(err));
    endtask

    task automatic load_tables();
        for (int n = 0; n < num_nodes; n++) begin
            deg_tbl[n] = degree_w'(1 + $urandom % max_degree);
            for (int i = 0; i < max_degree; i++)
                nbr_tbl[n][i] = node_id_w'($urandom);
            for (int l = 0; l < num_lanes; l++)
                fv_tbl[n][l] = lane_w'($urandom);
        end
        deg_tbl[zero_node] = '0;
        deg_tbl[1] = 4'd1;
        deg_tbl[2] = 4'd8;
        deg_tbl[3] = 4'd5;
        // unused top slots point at a heavy node so a leak shows up
        nbr_tbl[1][1] = 7'd126;
        nbr_tbl[3][5] = 7'd126;
        fv_tbl[126][0] = 8'hff;
        fv_tbl[126][1] = 8'hff;
        for (int n = 0; n < num_nodes; n++) begin
            write_neighbors(n);
            write_features(n);
        end
    endtask

    task automatic run_task(input string name, input logic [node_id_w-1:0] target);
        logic                  err;
        logic [apb_data_w-1:0] status;
        logic [apb_data_w-1:0] result;
        apb_write(task_addr, 32'(target), err);
        expect_eq({name, " accept"}, 32'd0, 32'(err));
        wait_idle(status);
        apb_read(result_addr, result);
        expect_eq({name, " result"}, model_result(target), result);
        expect_eq({name, " last target"}, 32'(target), 32'(status[14:8]));
    endtask

    initial begin
        logic                  err;
        logic [apb_data_w-1:0] rd;
        logic [node_id_w-1:0]  n;
        void'($urandom(69361));
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        apb_read(status_addr, rd);
        expect_eq("reset status", 32'd0, rd);
        apb_read(result_addr, rd);
        expect_eq("reset result", 32'd0, rd);

        load_tables();

        // rejected accesses
        apb_write(task_addr, 32'(zero_node), err);
        expect_eq("degree 0 task pslverr", 32'd1, 32'(err));
        apb_read(status_addr, rd);
        expect_eq("degree 0 task busy", 32'd0, 32'(rd[0]));
        apb_write(status_addr, 32'd1, err);
        expect_eq("region 3 write pslverr", 32'd1, 32'(err));
        apb_read(status_addr, rd);
        expect_eq("region 3 write busy", 32'd0, 32'(rd[0]));

        run_task("degree 1", 7'd1);
        run_task("degree 8", 7'd2);
        run_task("degree 5", 7'd3);

        // second task while the first one runs
        apb_write(task_addr, 32'd2, err);
        expect_eq("busy first accept", 32'd0, 32'(err));
        apb_write(task_addr, 32'd5, err);
        expect_eq("busy task pslverr", 32'd1, 32'(err));
        wait_idle(rd);
        expect_eq("busy last target", 32'd2, 32'(rd[14:8]));
        apb_read(result_addr, rd);
        expect_eq("busy result", model_result(7'd2), rd);

        run_task("rewrite before", 7'd4);
        n = nbr_tbl[4][0];
        for (int l = 0; l < num_lanes; l++)
            fv_tbl[n][l] ^= lane_w'(1 + $urandom % 255);   // always a change
        write_features(int'(n));
        run_task("rewrite after", 7'd4);

        repeat (num_random)
            run_task("random", node_id_w'($urandom % (num_nodes - 1)));

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
